// File: common/apuBusPkg.sv
// Bus-level types of the APU, shared by the sprite DMA RTL and its testbench
// Holds the address word and one processor bus cycle
package apuBusPkg;

	// Address split into page and offset within the page
	typedef struct packed {
		logic [7:0] hi;    // Page
		logic [7:0] lo;    // Offset
	} addrBytesT;

	// One address word, read whole by the bus side and built by bytes on the DMA side
	typedef union packed {
		logic [15:0] word;
		addrBytesT   bytes;
	} addrWordU;

	// One bus cycle as it leaves the APU
	typedef struct packed {
		addrWordU   addr;
		logic       rnw;     // 1 = read
		logic [7:0] data;    // Write data, don't care on reads
	} busCycleT;

endpackage

// File: common/spriteDmaPkg.sv
// Control types of the sprite DMA block
// Used by the sequencer and by every block that follows its strobes
package spriteDmaPkg;

	// Direction of the current sprite cycle
	typedef enum logic {
		phaseGet = 1'b0,    // RAM to buffer
		phasePut = 1'b1     // Buffer to OAM port
	} dmaPhaseT;

	// Per-cycle strobes from the sequencer
	typedef struct packed {
		logic sprCpu;       // Sprite get on the bus
		logic sprPpu;       // Sprite put on the bus
		logic step;         // Advance the low counter
	} sprStrobesT;

endpackage

// File: spriteDma/spriteDmaAddr.sv
// Sprite DMA source address: page from the $4014 write, low byte counted per put
module spriteDmaAddr import apuBusPkg::*, spriteDmaPkg::*; (
	input  logic       aclk,
	input  logic       rstN,
	input  logic       load,
	input  logic [7:0] page,
	input  sprStrobesT strobes,
	output addrWordU   sprAddr,
	output logic       endCount
);

	logic [7:0] pageQ;
	logic [7:0] lowQ;

	always_ff @(posedge aclk) begin
		if (load) begin
			pageQ <= page;                // Byte written to $4014
		end
	end

	always_ff @(posedge aclk) begin
		if (!rstN) begin
			lowQ <= 8'h00;
		end else if (load) begin
			lowQ <= 8'h00;                // Every transfer starts at offset 00
		end else if (strobes.step) begin
			lowQ <= lowQ + 8'd1;
		end
	end

	always_comb begin
		sprAddr.bytes.hi = pageQ;
		sprAddr.bytes.lo = lowQ;
	end

	// High during the last byte, so the put at FF ends the transfer
	assign endCount = (lowQ == 8'hFF);

	// A reload must never race a counter step from the sequencer
	assert property (@(posedge aclk) disable iff (!rstN)
		!(load && strobes.step))
		else $error("spriteDmaAddr: load and step in the same cycle");

endmodule

// File: spriteDma/spriteDmaControl.sv
// Sprite DMA sequencer: after the $4014 write it waits for a processor read,
// then alternates get and put cycles and holds the processor off through rdy
module spriteDmaControl import spriteDmaPkg::*; (
	input  logic       aclk,
	input  logic       rstN,
	input  logic       w4014,
	input  logic       cpuRnw,
	input  logic       runDmc,
	input  logic       dmcRdy,
	input  logic       endCount,
	output sprStrobesT strobes,
	output logic       rdy
);

	logic     startPending;    // Armed by $4014, waits for a read cycle
	logic     active;          // Transfer running, cleared by the last put
	dmaPhaseT phase;           // Get/put toggle
	logic     beginDma;
	logic     running;
	logic     advance;
	logic     lastPut;
	logic     accept;

	// The processor ignores a halt on write cycles, so DMA only
	// starts once the halted cycle is a read
	assign beginDma = startPending & cpuRnw;
	assign running  = active | beginDma;
	assign advance  = running & ~runDmc;       // DMC owns the bus otherwise
	assign lastPut  = strobes.sprPpu & endCount;
	assign accept   = w4014 & ~active & ~beginDma;

	always_comb begin
		strobes        = '0;
		strobes.sprCpu = advance & (phase == phaseGet);
		strobes.sprPpu = advance & (phase == phasePut);
		strobes.step   = advance & (phase == phasePut);   // Count after each put
	end

	always_ff @(posedge aclk) begin
		if (!rstN) begin
			startPending <= 1'b0;
		end else if (accept) begin
			startPending <= 1'b1;
		end else if (beginDma) begin
			startPending <= 1'b0;        // Handed over to active
		end
	end

	always_ff @(posedge aclk) begin
		if (!rstN) begin
			active <= 1'b0;
		end else if (lastPut) begin
			active <= 1'b0;
		end else if (beginDma) begin
			active <= 1'b1;
		end
	end

	// Toggle only moves on cycles the DMA actually owns; a first read
	// landing on a put phase becomes an idle alignment cycle
	always_ff @(posedge aclk) begin
		if (!rstN) begin
			phase <= phaseGet;
		end else if (advance) begin
			phase <= (phase == phaseGet) ? phasePut : phaseGet;
		end
	end

	// Processor halted from the cycle after $4014 until the cycle after the last put
	assign rdy = ~(startPending | active) & dmcRdy;

	assert property (@(posedge aclk) disable iff (!rstN)
		!(strobes.sprCpu && strobes.sprPpu))
		else $error("spriteDmaControl: get and put in one cycle");

	// DMC stall freezes all sprite traffic
	assert property (@(posedge aclk) disable iff (!rstN)
		runDmc |-> !(strobes.sprCpu || strobes.sprPpu || strobes.step))
		else $error("spriteDmaControl: sprite strobe during DMC stall");

	// Processor must already be halted on any sprite cycle
	assert property (@(posedge aclk) disable iff (!rstN)
		(strobes.sprCpu || strobes.sprPpu) |-> !rdy)
		else $error("spriteDmaControl: sprite cycle with rdy high");

	// A $4014 write mid-transfer must not arm another transfer
	assert property (@(posedge aclk) disable iff (!rstN)
		(w4014 && active) |=> !startPending)
		else $error("spriteDmaControl: w4014 accepted during transfer");

endmodule

// File: spriteDma/spriteDmaBuffer.sv
// One-byte sprite DMA buffer: RAM byte taken on a get, sent to the OAM port on the put
module spriteDmaBuffer import spriteDmaPkg::*; (
	input  logic       aclk,
	input  logic       rstN,
	input  sprStrobesT strobes,
	input  logic [7:0] dbIn,
	output logic [7:0] bufData
);

	logic holding;    // A get has filled the buffer since the last put

	always_ff @(posedge aclk) begin
		if (strobes.sprCpu) begin
			bufData <= dbIn;             // RAM answers within the get cycle
		end
	end

	always_ff @(posedge aclk) begin
		if (!rstN) begin
			holding <= 1'b0;
		end else if (strobes.sprCpu) begin
			holding <= 1'b1;
		end else if (strobes.sprPpu) begin
			holding <= 1'b0;
		end
	end

	// Put must never send a stale or empty buffer
	assert property (@(posedge aclk) disable iff (!rstN)
		strobes.sprPpu |-> holding)
		else $error("spriteDmaBuffer: put without a preceding get");

endmodule

// File: src/addressBusMux.sv
// Bus arbitration between sprite DMA, DMC DMA and the processor
// Fixed priority: sprite put, sprite get, DMC, then the processor cycle
module addressBusMux import apuBusPkg::*, spriteDmaPkg::*; #(
	parameter logic [15:0] OAM_PORT = 16'h2004
) (
	input  sprStrobesT strobes,
	input  logic       dmcAb,
	input  addrWordU   dmcAddr,
	input  addrWordU   sprAddr,
	input  logic [7:0] bufData,
	input  busCycleT   cpuBus,
	output busCycleT   bus
);

	always_comb begin
		bus = cpuBus;                        // Processor owns the bus by default
		if (strobes.sprPpu) begin
			bus.addr.word = OAM_PORT;        // Buffer to video chip
			bus.rnw       = 1'b0;
			bus.data      = bufData;
		end else if (strobes.sprCpu) begin
			bus.addr = sprAddr;              // RAM to buffer
			bus.rnw  = 1'b1;
		end else if (dmcAb) begin
			bus.addr = dmcAddr;              // Sample fetch
			bus.rnw  = 1'b1;
		end
	end

endmodule

// File: src/spriteDmaUnit.sv
// Sprite DMA block of the APU with bus arbitration
// Connects address, sequencer, buffer and bus multiplexer
module spriteDmaUnit import apuBusPkg::*, spriteDmaPkg::*; #(
	parameter logic [15:0] OAM_PORT = 16'h2004
) (
	input  logic       aclk,
	input  logic       rstN,
	input  busCycleT   cpuBus,     // Cycle the processor wants
	input  logic       w4014,
	input  logic [7:0] cpuData,
	input  logic [7:0] dbIn,       // Read data from RAM
	input  logic       runDmc,
	input  logic       dmcAb,
	input  logic       dmcRdy,
	input  addrWordU   dmcAddr,
	output busCycleT   bus,
	output logic       rdy
);

	sprStrobesT strobes;
	addrWordU   sprAddr;
	logic       endCount;
	logic [7:0] bufData;

	spriteDmaAddr u_spriteDmaAddr (
		.aclk    (aclk),
		.rstN    (rstN),
		.load    (w4014),
		.page    (cpuData),
		.strobes (strobes),
		.sprAddr (sprAddr),
		.endCount(endCount)
	);

	spriteDmaControl u_spriteDmaControl (
		.aclk    (aclk),
		.rstN    (rstN),
		.w4014   (w4014),
		.cpuRnw  (cpuBus.rnw),
		.runDmc  (runDmc),
		.dmcRdy  (dmcRdy),
		.endCount(endCount),
		.strobes (strobes),
		.rdy     (rdy)
	);

	spriteDmaBuffer u_spriteDmaBuffer (
		.aclk   (aclk),
		.rstN   (rstN),
		.strobes(strobes),
		.dbIn   (dbIn),
		.bufData(bufData)
	);

	addressBusMux #(
		.OAM_PORT(OAM_PORT)
	) u_addressBusMux (
		.strobes(strobes),
		.dmcAb  (dmcAb),
		.dmcAddr(dmcAddr),
		.sprAddr(sprAddr),
		.bufData(bufData),
		.cpuBus (cpuBus),
		.bus    (bus)
	);

endmodule

// File: verif/spriteDmaChecker.sv
// Bus monitor for the sprite DMA unit that predicts rdy and each get/put from
// the $4014 write and its own copy of RAM, and counts what goes wrong
module spriteDmaChecker import apuBusPkg::*; #(
	parameter logic [15:0] OAM_PORT = 16'h2004
) (
	input  logic     aclk,
	input  logic     rstN,
	input  busCycleT cpuBus,
	input  logic     w4014,
	input  logic [7:0] cpuData,
	input  logic     runDmc,
	input  logic     dmcAb,
	input  logic     dmcRdy,
	input  addrWordU dmcAddr,
	input  busCycleT bus,
	input  logic     rdy,
	output int       mismatchCount,
	output int       otherCount,
	output int       doneCount,
	output logic     busy          // Transfer pending or running
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [7:0] ramImage [65536];    // Filled by the testbench at time 0
	logic [7:0] page;
	logic [7:0] ptr;                 // Next offset to get and put
	logic       holding;             // Get seen, put still owed
	logic       started;             // First processor read seen
	logic       firstFree;           // One alignment cycle allowed

	task automatic reportMismatch(input string name, input logic [31:0] expVal,
			input logic [31:0] gotVal);
		$display("MISMATCH at %0d ns: %s expected %h, got %h",
			$time, name, expVal, gotVal);
		mismatchCount++;
	endtask

	task automatic reportFault(input string what);
		$display("ERROR at %0d ns: %s", $time, what);
		otherCount++;
	endtask

	always @(posedge aclk) begin
		busCycleT passBus;
		logic     expRdy;
		logic     isGet;
		logic     isPut;
		logic     startedNow;
		logic     wasBusy;
		if (!rstN) begin
			busy          = 1'b0;
			holding       = 1'b0;
			started       = 1'b0;
			firstFree     = 1'b0;
			ptr           = 8'h00;
			page          = 8'h00;
			mismatchCount = 0;
			otherCount    = 0;
			doneCount     = 0;
		end else begin
			wasBusy = busy;
			expRdy  = !busy && dmcRdy;
			if (rdy !== expRdy)
				reportMismatch("rdy", expRdy, rdy);
			passBus = cpuBus;                // Processor cycle unless the DMC has the bus
			if (dmcAb) begin
				passBus.addr = dmcAddr;
				passBus.rnw  = 1'b1;
			end
			isPut      = busy && !bus.rnw && (bus.addr.word == OAM_PORT);
			isGet      = busy && bus.rnw && (bus.addr.bytes.hi == page);
			startedNow = started || (busy && cpuBus.rnw);
			if ((isGet || isPut) && runDmc)
				reportFault("sprite cycle during a DMC stall");
			if ((isGet || isPut) && !startedNow)
				reportFault("sprite cycle before the first processor read");
			if (isGet) begin
				if (holding)
					reportFault("second get without a put in between");
				if (bus.addr.bytes.lo !== ptr)
					reportMismatch("bus.addr", {page, ptr}, bus.addr.word);
				holding = 1'b1;
			end else if (isPut) begin
				if (!holding)
					reportFault("put without a preceding get");
				if (bus.data !== ramImage[{page, ptr}])
					reportMismatch("bus.data", ramImage[{page, ptr}], bus.data);
				holding = 1'b0;
			end else begin
				if (bus !== passBus)
					reportMismatch("bus", passBus, bus);
				if (startedNow && !runDmc && !firstFree)
					reportFault("missing sprite cycle while the bus was free");
			end
			if (startedNow && !runDmc)
				firstFree = 1'b0;
			started = startedNow;
			if (isPut) begin
				if (ptr == 8'hFF) begin      // Last byte done
					busy    = 1'b0;
					started = 1'b0;
					doneCount++;
				end
				ptr = ptr + 8'd1;
			end
			if (w4014 && !wasBusy) begin
				busy      = 1'b1;
				page      = cpuData;
				ptr       = 8'h00;
				holding   = 1'b0;
				started   = 1'b0;
				firstFree = 1'b1;
			end
		end
	end

endmodule

// File: verif/tbSpriteDma.sv
// Testbench top for the sprite DMA unit: models processor, RAM and DMC,
// and runs a table of transfers that the checker follows on the bus
module tbSpriteDma import apuBusPkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [15:0] OAM_PORT = 16'h2004;
	localparam int ROWS      = 5;
	localparam int ROW_LIMIT = 1500;    // Cycles allowed per transfer

	typedef struct packed {
		logic [7:0] page;
		logic [7:0] nWrites;      // Processor writes before the first read
		logic [9:0] stallStart;   // Read cycle where the DMC stall begins
		logic [3:0] stallLen;     // 0 means no stall
		logic       dropRdy;      // Pull dmcRdy low once the transfer is over
	} rowT;

	logic       aclk;
	logic       rstN;
	busCycleT   cpuBus;
	logic       w4014;
	logic [7:0] cpuData;
	logic [7:0] dbIn;
	logic       runDmc;
	logic       dmcAb;
	logic       dmcRdy;
	addrWordU   dmcAddr;
	busCycleT   bus;
	logic       rdy;
	logic [7:0] ram [65536];
	logic [15:0] lfsrState;
	rowT        scenarios [ROWS];
	int         mismatchCount;
	int         otherCount;
	int         doneCount;
	logic       checkerBusy;
	int         tbErrors;
	bit         timedOut;

	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	assign dbIn = ram[bus.addr.word];    // RAM answers within the cycle

	spriteDmaUnit #(.OAM_PORT(OAM_PORT)) u_spriteDmaUnit (
		.aclk(aclk), .rstN(rstN), .cpuBus(cpuBus), .w4014(w4014), .cpuData(cpuData),
		.dbIn(dbIn), .runDmc(runDmc), .dmcAb(dmcAb), .dmcRdy(dmcRdy),
		.dmcAddr(dmcAddr), .bus(bus), .rdy(rdy)
	);

	spriteDmaChecker #(.OAM_PORT(OAM_PORT)) u_checker (
		.aclk(aclk), .rstN(rstN), .cpuBus(cpuBus), .w4014(w4014), .cpuData(cpuData),
		.runDmc(runDmc), .dmcAb(dmcAb), .dmcRdy(dmcRdy), .dmcAddr(dmcAddr),
		.bus(bus), .rdy(rdy), .mismatchCount(mismatchCount), .otherCount(otherCount),
		.doneCount(doneCount), .busy(checkerBusy)
	);

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	function automatic logic [7:0] randomByte();
		logic [7:0] b;
		for (int i = 0; i < 8; i++) begin
			b[i]      = lfsrState[0];
			lfsrState = lfsrNext(lfsrState);    // One step per bit
		end
		return b;
	endfunction

	function automatic busCycleT makeCycle(input logic [15:0] addr, input logic rnw,
			input logic [7:0] data);
		busCycleT c;
		c.addr.word = addr;
		c.rnw       = rnw;
		c.data      = data;
		return c;
	endfunction

	task automatic idleCycles(input int n, input logic rdyLevel);
		for (int i = 0; i < n; i++) begin
			@(negedge aclk);
			cpuBus = makeCycle(16'h8200 + i, i[0], i[7:0]);    // Reads and writes mixed
			runDmc = 1'b0;
			dmcAb  = 1'b0;
			dmcRdy = rdyLevel;
		end
	endtask

	task automatic runScenario(input rowT r, input int rowIdx);
		int cycle;
		int readIdx;
		int sStart;
		int sEnd;
		bit finished;
		cycle    = 0;
		finished = 1'b0;
		sStart   = r.stallStart;
		sEnd     = r.stallStart + r.stallLen;
		@(negedge aclk);
		w4014   = 1'b1;
		cpuData = r.page;
		cpuBus  = makeCycle(16'h4014, 1'b0, r.page);
		while (!finished && !timedOut) begin
			@(negedge aclk);
			w4014   = 1'b0;
			readIdx = cycle - r.nWrites;
			if (readIdx < 0)
				cpuBus = makeCycle(16'h0600 + cycle, 1'b0, cycle[7:0]);    // Writes ignore rdy
			else
				cpuBus = makeCycle(16'h8123, 1'b1, 8'h00);                 // Halted read
			runDmc       = (readIdx >= sStart) && (readIdx < sEnd);
			dmcAb        = runDmc && (readIdx == sEnd - 1);                // Grant at stall end
			dmcAddr.word = 16'hC000 + readIdx[7:0];
			@(posedge aclk);
			finished = rdy;
			cycle++;
			if (!finished && cycle > ROW_LIMIT) begin
				$display("Timeout: rdy stayed low for %0d cycles in scenario %0d", cycle, rowIdx);
				timedOut = 1'b1;
				tbErrors++;
			end
		end
	endtask

	initial begin
		rstN         = 1'b0;
		cpuBus       = makeCycle(16'h8000, 1'b1, 8'h00);
		w4014        = 1'b0;
		cpuData      = 8'h00;
		runDmc       = 1'b0;
		dmcAb        = 1'b0;
		dmcRdy       = 1'b1;
		dmcAddr.word = 16'hC000;
		tbErrors     = 0;
		timedOut     = 1'b0;
		lfsrState    = 16'd59911;
		for (int a = 0; a < 65536; a++) begin
			ram[a]                = randomByte();
			u_checker.ramImage[a] = ram[a];
		end
		// page, writes first, stall start, stall length, drop dmcRdy
		scenarios[0] = {8'h02, 8'd0, 10'd0,   4'd0, 1'b0};
		scenarios[1] = {8'h07, 8'd2, 10'd37,  4'd4, 1'b1};
		scenarios[2] = {8'h03, 8'd3, 10'd200, 4'd3, 1'b0};
		scenarios[3] = {8'h05, 8'd1, 10'd0,   4'd2, 1'b1};
		scenarios[4] = {8'hFF, 8'd0, 10'd511, 4'd2, 1'b0};
		repeat (10) @(negedge aclk);
		rstN = 1'b1;
		idleCycles(8, 1'b1);
		for (int r = 0; r < ROWS && !timedOut; r++) begin
			runScenario(scenarios[r], r);
			if (!timedOut) begin
				idleCycles(3, 1'b1);
				if (scenarios[r].dropRdy) begin
					idleCycles(4, 1'b0);
					idleCycles(2, 1'b1);
				end
			end
		end
		@(posedge aclk);
		@(negedge aclk);
		if (!timedOut && (doneCount != ROWS || checkerBusy)) begin
			$display("Only %0d of %0d transfers completed", doneCount, ROWS);
			tbErrors++;
		end
		$display("Errors: %0d mismatches, %0d protocol, %0d testbench",
			mismatchCount, otherCount, tbErrors);
		if (mismatchCount + otherCount + tbErrors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: vlog.f
common/apuBusPkg.sv
common/spriteDmaPkg.sv
spriteDma/spriteDmaAddr.sv
spriteDma/spriteDmaControl.sv
spriteDma/spriteDmaBuffer.sv
src/addressBusMux.sv
src/spriteDmaUnit.sv
verif/spriteDmaChecker.sv
verif/tbSpriteDma.sv
